// File: source/sram_pkg.sv
// Geometry is fixed by the 64x98 macro; offsets at or above REG_LIMIT answer SLVERR
`default_nettype none

package sram_pkg;

  // Array geometry
  localparam int ROW_BITS      = 98;
  localparam int ROW_ADDR_BITS = 6;
  localparam int SEG0_BITS     = 48;
  localparam int SEG1_BITS     = 48;
  localparam int SEG2_BITS     = 2;

  // AXI4-Lite address width, byte addressed
  localparam int AXI_ADDR_BITS = 8;

  // Register map
  // Words 0..3 write the staging row and read the window
  localparam logic [AXI_ADDR_BITS-1:0] REG_WORD0 = 8'h00;
  localparam logic [AXI_ADDR_BITS-1:0] REG_WORD1 = 8'h04;
  localparam logic [AXI_ADDR_BITS-1:0] REG_WORD2 = 8'h08;
  localparam logic [AXI_ADDR_BITS-1:0] REG_WORD3 = 8'h0C;
  localparam logic [AXI_ADDR_BITS-1:0] REG_CMD   = 8'h10;
  // First unmapped offset
  localparam logic [AXI_ADDR_BITS-1:0] REG_LIMIT = 8'h14;

  // Command word fields, op sits in bits 1:0
  localparam int CMD_ROW_LSB  = 8;
  localparam int CMD_MASK_LSB = 16;

  typedef enum logic [1:0] {
    op_none   = 2'd0,
    op_select = 2'd1,
    op_store  = 2'd2
  } cmd_op_e;

  typedef enum logic [1:0] {
    st_idle,
    st_wresp,
    st_rresp
  } bridge_state_e;

  // AXI response codes
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

endpackage

`default_nettype wire

// File: source/sram_port_if.sv
// Strobes are active low; q follows the addressed or held row one clock edge later
`timescale 1ns/1ps
`default_nettype none

interface sram_port_if;

  // Chip enable, low for one access
  logic                             cen;
  // Global write enable, low to write
  logic                             gwen;
  // Row address, captured while cen is low
  logic [sram_pkg::ROW_ADDR_BITS-1:0] a;
  // Write data for the whole row
  logic [sram_pkg::ROW_BITS-1:0]      d;
  // Per-bit write enables, active low
  // Only bits 47, 95 and 97 matter to the array
  logic [sram_pkg::ROW_BITS-1:0]      wen;
  // Read data, re-read every cycle
  logic [sram_pkg::ROW_BITS-1:0]      q;

  // Bridge side
  modport ctrl (
    output cen,
    output gwen,
    output a,
    output d,
    output wen,
    input  q
  );

  // Array side
  modport mem (
    input  cen,
    input  gwen,
    input  a,
    input  d,
    input  wen,
    output q
  );

endinterface

`default_nettype wire

// File: source/fpga_ram.sv
// No reset and no initial contents; dout shows the old word on a write (read-first)
`timescale 1ns/1ps
`default_nettype none

module fpga_ram #(
  parameter int DATA_WIDTH = 48,
  parameter int ADDR_WIDTH = 6
) (
  input  logic                  CLK,
  input  logic [ADDR_WIDTH-1:0] addr,
  input  logic [DATA_WIDTH-1:0] din,
  input  logic                  we,
  output logic [DATA_WIDTH-1:0] dout
);

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  // Storage array, maps onto block or distributed RAM
  logic [DATA_WIDTH-1:0] mem_q [DEPTH];

  // Write port
  always_ff @(posedge CLK) begin
    if (we) begin
      mem_q[addr] <= din;
    end
  end

  // Registered read of the contents before this edge
  always_ff @(posedge CLK) begin
    dout <= mem_q[addr];
  end

  // A write to an unknown row would corrupt an unknown word
  a_we_addr_known: assert property (
    @(posedge CLK) we |-> !$isunknown(addr)
  ) else $error("fpga_ram: write with unknown address");

endmodule

`default_nettype wire

// File: source/spsram_64x98.sv
// Single port, three write segments (48/48/2 bits); address held while cen is high
`timescale 1ns/1ps
`default_nettype none

module spsram_64x98 (
  input logic       CLK,
  sram_port_if.mem  port
);

  // Segment boundaries inside the row
  localparam int SEG1_LO = sram_pkg::SEG0_BITS;
  localparam int SEG2_LO = SEG1_LO + sram_pkg::SEG1_BITS;

  // Address last presented with cen low
  logic [sram_pkg::ROW_ADDR_BITS-1:0] addr_hold;
  // Address seen by the RAM slices
  logic [sram_pkg::ROW_ADDR_BITS-1:0] addr;

  // Slice write enables, active high
  logic ram0_we;
  logic ram1_we;
  logic ram2_we;

  // Slice read data
  logic [sram_pkg::SEG0_BITS-1:0] ram0_dout;
  logic [sram_pkg::SEG1_BITS-1:0] ram1_dout;
  logic [sram_pkg::SEG2_BITS-1:0] ram2_dout;

  // Capture on every enabled access
  always_ff @(posedge CLK) begin
    if (!port.cen) begin
      addr_hold <= port.a;
    end
  end

  // Idle cycles keep reading the held row
  assign addr = port.cen ? addr_hold : port.a;

  // Top bit of each segment's wen acts as that segment's enable
  assign ram0_we = !port.cen && !port.gwen && !port.wen[SEG1_LO-1];
  assign ram1_we = !port.cen && !port.gwen && !port.wen[SEG2_LO-1];
  assign ram2_we = !port.cen && !port.gwen && !port.wen[sram_pkg::ROW_BITS-1];

  // Low segment, row bits 47:0
  fpga_ram #(
    .DATA_WIDTH (sram_pkg::SEG0_BITS),
    .ADDR_WIDTH (sram_pkg::ROW_ADDR_BITS)
  ) ram0 (
    .CLK  (CLK),
    .addr (addr),
    .din  (port.d[SEG1_LO-1:0]),
    .we   (ram0_we),
    .dout (ram0_dout)
  );

  // Middle segment, row bits 95:48
  fpga_ram #(
    .DATA_WIDTH (sram_pkg::SEG1_BITS),
    .ADDR_WIDTH (sram_pkg::ROW_ADDR_BITS)
  ) ram1 (
    .CLK  (CLK),
    .addr (addr),
    .din  (port.d[SEG2_LO-1:SEG1_LO]),
    .we   (ram1_we),
    .dout (ram1_dout)
  );

  // Top segment, row bits 97:96
  fpga_ram #(
    .DATA_WIDTH (sram_pkg::SEG2_BITS),
    .ADDR_WIDTH (sram_pkg::ROW_ADDR_BITS)
  ) ram2 (
    .CLK  (CLK),
    .addr (addr),
    .din  (port.d[sram_pkg::ROW_BITS-1:SEG2_LO]),
    .we   (ram2_we),
    .dout (ram2_dout)
  );

  // Rejoin the row
  assign port.q = {ram2_dout, ram1_dout, ram0_dout};

  // After two idle edges the held row is re-read untouched,
  // so any movement of q means a write slipped through with cen high
  a_idle_no_write: assert property (
    @(posedge CLK) $past(port.cen) && $past(port.cen, 2) |-> $stable(port.q)
  ) else $error("spsram_64x98: row changed while cen was high");

endmodule

`default_nettype wire

// File: source/axil_row_bridge.sv
// One AXI4-Lite transaction at a time, no bursts, WSTRB ignored, full 32-bit words only
`timescale 1ns/1ps
`default_nettype none

module axil_row_bridge (
  input  logic                               CLK,
  input  logic                               arst_n,
  // Write address and data
  input  logic [sram_pkg::AXI_ADDR_BITS-1:0] awaddr,
  input  logic                               awvalid,
  output logic                               awready,
  input  logic [31:0]                        wdata,
  input  logic                               wvalid,
  output logic                               wready,
  // Write response
  output logic [1:0]                         bresp,
  output logic                               bvalid,
  input  logic                               bready,
  // Read address
  input  logic [sram_pkg::AXI_ADDR_BITS-1:0] araddr,
  input  logic                               arvalid,
  output logic                               arready,
  // Read data
  output logic [31:0]                        rdata,
  output logic [1:0]                         rresp,
  output logic                               rvalid,
  input  logic                               rready,
  // Array port
  sram_port_if.ctrl                          mem
);

  localparam int SEG1_LO = sram_pkg::SEG0_BITS;
  localparam int SEG2_LO = SEG1_LO + sram_pkg::SEG1_BITS;

  sram_pkg::bridge_state_e state_q;
  sram_pkg::bridge_state_e state_d;
  // High while a new request may be taken
  logic                               rdy_q;
  logic                               wr_fire;
  logic                               rd_fire;
  logic                               cmd_hit;
  // Word-aligned write offset and range check
  logic [sram_pkg::AXI_ADDR_BITS-1:0] wr_off;
  logic                               wr_err;
  logic                               rd_err;
  // Staging row and last command word
  logic [sram_pkg::ROW_BITS-1:0]      stage_q;
  logic [31:0]                        cmd_q;
  // Offset of the read in flight
  logic [sram_pkg::AXI_ADDR_BITS-1:0] rd_off_q;
  // Decoded command fields
  sram_pkg::cmd_op_e                  op;
  logic [2:0]                         mask;
  logic [sram_pkg::ROW_BITS-1:0]      seg_wen_n;
  // Port strobes and payload
  logic                               cen_q;
  logic                               gwen_q;
  logic [sram_pkg::ROW_BITS-1:0]      wen_q;
  logic [sram_pkg::ROW_ADDR_BITS-1:0] a_q;
  logic [sram_pkg::ROW_BITS-1:0]      d_q;

  // AW and W only taken together
  assign awready = rdy_q && awvalid && wvalid;
  assign wready  = rdy_q && awvalid && wvalid;
  // Write wins a tie
  assign arready = rdy_q && !(awvalid && wvalid);

  assign wr_fire = rdy_q && awvalid && wvalid;
  assign rd_fire = arready && arvalid;

  assign bvalid = (state_q == sram_pkg::st_wresp);
  assign rvalid = (state_q == sram_pkg::st_rresp);

  // Address decode
  assign wr_off  = {awaddr[sram_pkg::AXI_ADDR_BITS-1:2], 2'b00};
  assign wr_err  = (awaddr >= sram_pkg::REG_LIMIT);
  assign rd_err  = (araddr >= sram_pkg::REG_LIMIT);
  assign cmd_hit = wr_fire && !wr_err && (wr_off == sram_pkg::REG_CMD);

  // Command fields
  assign op   = sram_pkg::cmd_op_e'(wdata[1:0]);
  assign mask = wdata[sram_pkg::CMD_MASK_LSB +: 3];

  // Masked segments get all their wen bits low
  always_comb begin
    seg_wen_n = '1;
    if (mask[0]) begin
      seg_wen_n[SEG1_LO-1:0] = '0;
    end
    if (mask[1]) begin
      seg_wen_n[SEG2_LO-1:SEG1_LO] = '0;
    end
    if (mask[2]) begin
      seg_wen_n[sram_pkg::ROW_BITS-1:SEG2_LO] = '0;
    end
  end

  // Transaction FSM
  always_comb begin
    state_d = state_q;
    case (state_q)
      sram_pkg::st_idle: begin
        if (wr_fire) begin
          state_d = sram_pkg::st_wresp;
        end else if (rd_fire) begin
          state_d = sram_pkg::st_rresp;
        end
      end
      sram_pkg::st_wresp: begin
        if (bready) begin
          state_d = sram_pkg::st_idle;
        end
      end
      sram_pkg::st_rresp: begin
        if (rready) begin
          state_d = sram_pkg::st_idle;
        end
      end
      default: state_d = sram_pkg::st_idle;
    endcase
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state_q  <= sram_pkg::st_idle;
      rdy_q    <= 1'b0;
      bresp    <= sram_pkg::resp_okay;
      rresp    <= sram_pkg::resp_okay;
      rd_off_q <= '0;
    end else begin
      state_q <= state_d;
      rdy_q   <= (state_d == sram_pkg::st_idle);
      if (wr_fire) begin
        bresp <= wr_err ? sram_pkg::resp_slverr : sram_pkg::resp_okay;
      end
      if (rd_fire) begin
        rresp    <= rd_err ? sram_pkg::resp_slverr : sram_pkg::resp_okay;
        rd_off_q <= {araddr[sram_pkg::AXI_ADDR_BITS-1:2], 2'b00};
      end
    end
  end

  // Staging row and command register, error writes change nothing
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      stage_q <= '0;
      cmd_q   <= '0;
    end else if (wr_fire && !wr_err) begin
      case (wr_off)
        sram_pkg::REG_WORD0: stage_q[31:0]  <= wdata;
        sram_pkg::REG_WORD1: stage_q[63:32] <= wdata;
        sram_pkg::REG_WORD2: stage_q[95:64] <= wdata;
        // Only two row bits live in word 3
        sram_pkg::REG_WORD3: stage_q[97:96] <= wdata[1:0];
        sram_pkg::REG_CMD:   cmd_q          <= wdata;
        default: ;
      endcase
    end
  end

  // One-cycle strobes for select and store
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      cen_q  <= 1'b1;
      gwen_q <= 1'b1;
      wen_q  <= '1;
    end else if (cmd_hit) begin
      cen_q  <= !(op == sram_pkg::op_select || op == sram_pkg::op_store);
      gwen_q <= (op != sram_pkg::op_store);
      wen_q  <= (op == sram_pkg::op_store) ? seg_wen_n : '1;
    end else begin
      cen_q  <= 1'b1;
      gwen_q <= 1'b1;
      wen_q  <= '1;
    end
  end

  // Row and data only matter while cen is low
  always_ff @(posedge CLK) begin
    if (cmd_hit) begin
      a_q <= wdata[sram_pkg::CMD_ROW_LSB +: sram_pkg::ROW_ADDR_BITS];
      d_q <= stage_q;
    end
  end

  assign mem.cen  = cen_q;
  assign mem.gwen = gwen_q;
  assign mem.wen  = wen_q;
  assign mem.a    = a_q;
  assign mem.d    = d_q;

  // Read window, unmapped offsets fall to zero
  always_comb begin
    case (rd_off_q)
      sram_pkg::REG_WORD0: rdata = mem.q[31:0];
      sram_pkg::REG_WORD1: rdata = mem.q[63:32];
      sram_pkg::REG_WORD2: rdata = mem.q[95:64];
      sram_pkg::REG_WORD3: rdata = {30'd0, mem.q[97:96]};
      sram_pkg::REG_CMD:   rdata = cmd_q;
      default:             rdata = '0;
    endcase
  end

  // Write response held until taken
  a_bvalid_hold: assert property (
    @(posedge CLK) disable iff (!arst_n)
    bvalid && !bready |=> bvalid && $stable(bresp)
  ) else $error("axil_row_bridge: bvalid dropped before bready");

  // Read data comes from the array, so this also checks q holds still
  a_rvalid_hold: assert property (
    @(posedge CLK) disable iff (!arst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
  ) else $error("axil_row_bridge: read response changed before rready");

  // Each command is a single access
  a_cen_pulse: assert property (
    @(posedge CLK) disable iff (!arst_n)
    !mem.cen |=> mem.cen
  ) else $error("axil_row_bridge: cen low for more than one cycle");

endmodule

`default_nettype wire

// File: source/sram_axil_top.sv
// AXI4-Lite view of one 64x98 array; single outstanding transaction, no byte strobes
`timescale 1ns/1ps
`default_nettype none

module sram_axil_top (
  input  logic                               CLK,
  input  logic                               arst_n,
  // Write address channel
  input  logic [sram_pkg::AXI_ADDR_BITS-1:0] awaddr,
  input  logic                               awvalid,
  output logic                               awready,
  // Write data channel
  input  logic [31:0]                        wdata,
  input  logic                               wvalid,
  output logic                               wready,
  // Write response channel
  output logic [1:0]                         bresp,
  output logic                               bvalid,
  input  logic                               bready,
  // Read address channel
  input  logic [sram_pkg::AXI_ADDR_BITS-1:0] araddr,
  input  logic                               arvalid,
  output logic                               arready,
  // Read data channel
  output logic [31:0]                        rdata,
  output logic [1:0]                         rresp,
  output logic                               rvalid,
  input  logic                               rready
);

  // Macro-style port between bridge and array
  sram_port_if u_port ();

  axil_row_bridge u_bridge (
    .CLK     (CLK),
    .arst_n  (arst_n),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .mem     (u_port)
  );

  // Geometry fixed by the macro
  spsram_64x98 u_sram (
    .CLK  (CLK),
    .port (u_port)
  );

endmodule

`default_nettype wire

// File: bench/tb_sram_axil.sv
// Model tracks only rows the bench has stored; any handshake wait longer than 64 cycles ends the run
`timescale 1ns/1ps
`default_nettype none

module tb_sram_axil;

  localparam int TIMEOUT_CYCLES = 64;

  logic                               CLK;
  logic                               arst_n;
  logic [sram_pkg::AXI_ADDR_BITS-1:0] awaddr;
  logic                               awvalid;
  logic                               awready;
  logic [31:0]                        wdata;
  logic                               wvalid;
  logic                               wready;
  logic [1:0]                         bresp;
  logic                               bvalid;
  logic                               bready;
  logic [sram_pkg::AXI_ADDR_BITS-1:0] araddr;
  logic                               arvalid;
  logic                               arready;
  logic [31:0]                        rdata;
  logic [1:0]                         rresp;
  logic                               rvalid;
  logic                               rready;

  // Reference copy of the array, staging row and command register
  logic [97:0] model_rows [64];
  logic [97:0] model_stage;
  logic [31:0] model_cmd;
  logic [5:0]  model_sel;
  logic [31:0] rng_state;
  // Random ready stalls
  logic        backpressure;
  // Offer a competing request while a response waits
  logic        probe;
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_failed;
  int          test_err_base;
  // Raised by a wait loop that ran out of cycles
  event        timeout_ev;

  sram_axil_top uut (
    .CLK     (CLK),
    .arst_n  (arst_n),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready)
  );

  always #2 CLK = ~CLK;

  // xorshift32
  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t ns: no %s within %0d cycles", $time, what, TIMEOUT_CYCLES);
    -> timeout_ev;
  endtask

  // Ends the run as soon as any wait gives up
  initial begin
    @(timeout_ev);
    $display("SOME TESTS FAILED");
    $finish;
  end

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    int          cycles;
    logic        hs;
    logic [31:0] r;
    resp = 2'b11;
    @(negedge CLK);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    cycles  = 0;
    hs      = 1'b0;
    // Sample ready mid low phase, well clear of both edges
    while (!hs) begin
      #1;
      hs = awready && wready;
      @(posedge CLK);
      cycles++;
      if (!hs) begin
        if (cycles >= TIMEOUT_CYCLES) begin
          report_timeout("write accept");
        end
        @(negedge CLK);
      end
    end
    @(negedge CLK);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    cycles  = 0;
    hs      = 1'b0;
    while (!hs) begin
      r      = next_random();
      bready = backpressure ? r[0] : 1'b1;
      if (probe) begin
        araddr  = sram_pkg::REG_CMD;
        arvalid = 1'b1;
      end
      #1;
      if (probe) begin
        check_equal("arready", {31'd0, arready}, 32'd0);
      end
      hs = bvalid && bready;
      if (hs) begin
        resp = bresp;
      end
      @(posedge CLK);
      cycles++;
      if (!hs) begin
        if (cycles >= TIMEOUT_CYCLES) begin
          report_timeout("write response");
        end
        @(negedge CLK);
      end
    end
    @(negedge CLK);
    bready  = 1'b0;
    arvalid = 1'b0;
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int          cycles;
    logic        hs;
    logic [31:0] r;
    data = 32'd0;
    resp = 2'b11;
    @(negedge CLK);
    araddr  = addr;
    arvalid = 1'b1;
    cycles  = 0;
    hs      = 1'b0;
    while (!hs) begin
      #1;
      hs = arready;
      @(posedge CLK);
      cycles++;
      if (!hs) begin
        if (cycles >= TIMEOUT_CYCLES) begin
          report_timeout("read accept");
        end
        @(negedge CLK);
      end
    end
    @(negedge CLK);
    arvalid = 1'b0;
    cycles  = 0;
    hs      = 1'b0;
    while (!hs) begin
      r      = next_random();
      rready = backpressure ? r[0] : 1'b1;
      // Unmapped probe address, so a wrongly accepted write does no harm
      if (probe) begin
        awaddr  = 8'hFC;
        awvalid = 1'b1;
        wvalid  = 1'b1;
      end
      #1;
      if (probe) begin
        check_equal("awready", {31'd0, awready}, 32'd0);
        check_equal("wready", {31'd0, wready}, 32'd0);
      end
      hs = rvalid && rready;
      if (hs) begin
        data = rdata;
        resp = rresp;
      end
      @(posedge CLK);
      cycles++;
      if (!hs) begin
        if (cycles >= TIMEOUT_CYCLES) begin
          report_timeout("read response");
        end
        @(negedge CLK);
      end
    end
    @(negedge CLK);
    rready  = 1'b0;
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  // Four random words into the staging row
  task automatic fill_stage_random();
    logic [31:0] r;
    logic [1:0]  resp;
    int          i;
    for (i = 0; i < 4; i++) begin
      r = next_random();
      axil_write({4'd0, i[1:0], 2'b00}, r, resp);
      check_equal("bresp", {30'd0, resp}, {30'd0, sram_pkg::resp_okay});
      case (i)
        0:       model_stage[31:0]  = r;
        1:       model_stage[63:32] = r;
        2:       model_stage[95:64] = r;
        default: model_stage[97:96] = r[1:0];
      endcase
    end
  endtask

  task automatic send_cmd(input sram_pkg::cmd_op_e op, input logic [5:0] row,
                          input logic [2:0] mask);
    logic [31:0] w;
    logic [1:0]  resp;
    w        = 32'd0;
    w[1:0]   = op;
    w[13:8]  = row;
    w[18:16] = mask;
    axil_write(sram_pkg::REG_CMD, w, resp);
    check_equal("bresp", {30'd0, resp}, {30'd0, sram_pkg::resp_okay});
    model_cmd = w;
    // Segments of 48, 48 and 2 bits
    if (op == sram_pkg::op_store) begin
      if (mask[0]) begin
        model_rows[row][47:0] = model_stage[47:0];
      end
      if (mask[1]) begin
        model_rows[row][95:48] = model_stage[95:48];
      end
      if (mask[2]) begin
        model_rows[row][97:96] = model_stage[97:96];
      end
    end
    if (op != sram_pkg::op_none) begin
      model_sel = row;
    end
  endtask

  // Read all four window words of the last addressed row
  task automatic check_window();
    logic [31:0] w;
    logic [1:0]  resp;
    logic [97:0] exp;
    int          i;
    exp = model_rows[model_sel];
    for (i = 0; i < 4; i++) begin
      axil_read({4'd0, i[1:0], 2'b00}, w, resp);
      check_equal("rresp", {30'd0, resp}, {30'd0, sram_pkg::resp_okay});
      if (i < 3) begin
        check_equal($sformatf("rdata word%0d", i), w, exp[i*32 +: 32]);
      end else begin
        check_equal("rdata word3", w, {30'd0, exp[97:96]});
        check_equal("rdata word3[31:2]", {2'b00, w[31:2]}, 32'd0);
      end
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors != test_err_base) begin
      tests_failed++;
    end
    $display("test %0d %s: %s", tests_run, name, (errors != test_err_base) ? "fail" : "pass");
    test_err_base = errors;
  endtask

  initial begin
    logic [31:0] w;
    logic [31:0] r;
    logic [1:0]  resp;
    logic [5:0]  row;
    logic [5:0]  rows [6];
    int          order [6];
    int          i;
    int          j;
    int          t;
    CLK          = 1'b0;
    arst_n       = 1'b0;
    awaddr       = '0;
    awvalid      = 1'b0;
    wdata        = '0;
    wvalid       = 1'b0;
    bready       = 1'b0;
    araddr       = '0;
    arvalid      = 1'b0;
    rready       = 1'b0;
    rng_state    = 32'h8aa831fc;
    backpressure = 1'b0;
    probe        = 1'b0;
    model_stage  = '0;
    model_cmd    = '0;
    model_sel    = '0;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_err_base = 0;
    repeat (5) @(posedge CLK);
    @(negedge CLK);
    arst_n = 1'b1;

    // Quiet bus after reset
    repeat (8) begin
      @(negedge CLK);
      #1;
      check_equal("bvalid", {31'd0, bvalid}, 32'd0);
      check_equal("rvalid", {31'd0, rvalid}, 32'd0);
    end
    axil_read(sram_pkg::REG_CMD, w, resp);
    check_equal("rresp", {30'd0, resp}, {30'd0, sram_pkg::resp_okay});
    check_equal("rdata cmd", w, 32'd0);
    end_test("reset state");

    fill_stage_random();
    r = next_random();
    row = r[5:0];
    send_cmd(sram_pkg::op_store, row, 3'b111);
    send_cmd(sram_pkg::op_select, row, 3'b000);
    check_window();
    end_test("full store and select");

    // Pattern A everywhere, then pattern B into one segment only
    r = next_random();
    row = r[5:0];
    for (i = 0; i < 3; i++) begin
      fill_stage_random();
      send_cmd(sram_pkg::op_store, row, 3'b111);
      fill_stage_random();
      send_cmd(sram_pkg::op_store, row, 3'b001 << i);
      send_cmd(sram_pkg::op_select, row, 3'b000);
      check_window();
    end
    end_test("segment masking");

    // Step of 11 is odd, so six rows stay distinct
    r = next_random();
    row = r[5:0];
    for (i = 0; i < 6; i++) begin
      rows[i]  = row;
      order[i] = i;
      row      = row + 6'd11;
      fill_stage_random();
      send_cmd(sram_pkg::op_store, rows[i], 3'b111);
    end
    for (i = 5; i > 0; i--) begin
      r        = next_random();
      j        = {24'd0, r[7:0]} % (i + 1);
      t        = order[i];
      order[i] = order[j];
      order[j] = t;
    end
    for (i = 0; i < 6; i++) begin
      send_cmd(sram_pkg::op_select, rows[order[i]], 3'b000);
      check_window();
      // Held address keeps the same row in the window
      check_window();
    end
    end_test("row independence");

    // Unmapped writes and reads
    axil_write(sram_pkg::REG_LIMIT, 32'hDEADBEEF, resp);
    check_equal("bresp", {30'd0, resp}, {30'd0, sram_pkg::resp_slverr});
    axil_write(8'hFC, 32'h12345678, resp);
    check_equal("bresp", {30'd0, resp}, {30'd0, sram_pkg::resp_slverr});
    axil_read(sram_pkg::REG_LIMIT, w, resp);
    check_equal("rresp", {30'd0, resp}, {30'd0, sram_pkg::resp_slverr});
    check_equal("rdata slverr", w, 32'd0);
    axil_read(8'h80, w, resp);
    check_equal("rresp", {30'd0, resp}, {30'd0, sram_pkg::resp_slverr});
    check_equal("rdata slverr", w, 32'd0);
    axil_read(sram_pkg::REG_CMD, w, resp);
    check_equal("rdata cmd", w, model_cmd);
    check_window();
    // Staging row must still hold the last good fill
    row = model_sel + 6'd1;
    send_cmd(sram_pkg::op_store, row, 3'b111);
    check_window();
    backpressure = 1'b1;
    probe        = 1'b1;
    for (i = 0; i < 4; i++) begin
      fill_stage_random();
      r = next_random();
      row = r[5:0];
      send_cmd(sram_pkg::op_store, row, r[10:8]);
      send_cmd(sram_pkg::op_select, row, 3'b000);
      check_window();
    end
    backpressure = 1'b0;
    probe        = 1'b0;
    end_test("errors and back-pressure");

    $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
source/sram_pkg.sv
source/sram_port_if.sv
source/fpga_ram.sv
source/spsram_64x98.sv
source/axil_row_bridge.sv
source/sram_axil_top.sv
bench/tb_sram_axil.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then search the log for the fail message

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_sram_axil \
  -Mdir obj_dir -o tb_sram_axil_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_sram_axil_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
  exit 1
fi
exit 0
